//--- rtl/cpu16_pkg.sv
package cpu16_pkg;

    // Basic scalar types
    typedef logic [15:0] word_t;                    // Data or address word
    typedef logic [2:0]  reg_idx_t;                 // Register index
    typedef logic [3:0]  opcode_t;                  // Major opcode
    typedef logic [4:0]  imm5_t;                    // Raw immediate field

    // Opcode encodings used by decode
    localparam opcode_t OPC_NOP    = 4'b0000;       // Bubble, also the flush value
    localparam opcode_t OPC_BRANCH = 4'b1100;       // PC relative branch

    // Register form, bit 11 clear
    typedef struct packed {
        opcode_t  opcode;                           // Bits 15..12
        logic     imm_flag;                         // Bit 11, zero here
        reg_idx_t rd;                               // Bits 10..8
        reg_idx_t rs1;                              // Bits 7..5
        logic [1:0] unused;                         // Bits 4..3, ignored
        reg_idx_t rs2;                              // Bits 2..0
    } instr_r_t;

    // Immediate form, bit 11 set
    typedef struct packed {
        opcode_t  opcode;                           // Bits 15..12
        logic     imm_flag;                         // Bit 11, one here
        reg_idx_t rd;                               // Bits 10..8
        reg_idx_t rs1;                              // Bits 7..5
        imm5_t    imm;                              // Bits 4..0
    } instr_i_t;

    // One instruction word, two decodings of the low bits
    typedef union packed {
        instr_r_t r;                                // rs2 view
        instr_i_t i;                                // Immediate view
    } instr_word_u;

endpackage

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file import cpu16_pkg::*; #(
    parameter int NUM_REGS = 8                      // 8 or 4 entries
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     wr_en,                         // Writeback strobe
    input  reg_idx_t wr_addr,                       // Writeback register
    input  word_t    wr_data,                       // Writeback value
    input  reg_idx_t rd_addr_a,                     // rs1 index
    input  reg_idx_t rd_addr_b,                     // rs2 index
    output word_t    rd_data_a,                     // rs1 value
    output word_t    rd_data_b                      // rs2 value
);

    word_t regs [NUM_REGS];                         // r0 slot never written

    logic wr_ok;                                    // Write lands in a real register

    // r0 and out-of-range indices are not writable
    assign wr_ok = wr_en && (wr_addr != '0) && (int'(wr_addr) < NUM_REGS);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;                      // All registers clear
            end
        end else if (wr_ok) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Shared read path for both ports
    function automatic word_t read_port(reg_idx_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;                             // r0 hardwired
        end else if (int'(addr) >= NUM_REGS) begin
            value = '0;                             // Missing entries read zero
        end else if (wr_ok && (wr_addr == addr)) begin
            value = wr_data;                        // Same-cycle write bypass
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

    // r0 storage stays zero through writes aimed at it
    a_r0_zero : assert property (
        @(posedge clk) disable iff (reset)
        regs[0] == '0
    ) else $error("register_file: r0 storage holds a nonzero value");

    // Writeback must only target implemented registers
    a_wr_addr_range : assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> (int'(wr_addr) < NUM_REGS)
    ) else $error("register_file: write to r%0d beyond NUM_REGS", wr_addr);

endmodule

//--- rtl/imm_branch_gen.sv
`timescale 1ns/1ps

module imm_branch_gen import cpu16_pkg::*; (
    input  word_t       pc,                         // PC of the decoded word
    input  instr_word_u instr,                      // Read through the I view
    output word_t       imm_ext,                    // Zero-extended imm for op2
    output word_t       branch_target,              // pc + (sext(imm) << 2)
    output logic        is_branch                   // Opcode is a branch
);

    localparam int EXT_BITS = $bits(word_t) - $bits(imm5_t);   // 11 fill bits

    imm5_t imm_raw;                                 // Low five bits of the word
    word_t imm_sext;                                // Sign-extended imm
    word_t branch_offset;                           // Word-scaled displacement

    assign imm_raw = instr.i.imm;

    // Operand form, unsigned
    assign imm_ext = {{EXT_BITS{1'b0}}, imm_raw};

    // Branch displacement is signed, counted in 4-byte steps
    assign imm_sext      = {{EXT_BITS{imm_raw[4]}}, imm_raw};
    assign branch_offset = imm_sext << 2;           // Top bits drop off, wraps mod 2^16
    assign branch_target = pc + branch_offset;

    // Only the branch opcode is allowed to move the target
    assign is_branch = (instr.i.opcode == OPC_BRANCH);

endmodule

//--- rtl/decode_latch.sv
`timescale 1ns/1ps

module decode_latch import cpu16_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,                      // Hold all outputs
    input  logic        flush,                      // Squash, wins over stall
    input  instr_word_u instr,                      // Raw instruction word
    input  word_t       rs1_val,                    // From register file
    input  word_t       rs2_val,                    // From register file
    input  word_t       imm_ext,                    // Zero-extended imm
    input  word_t       branch_target,              // Computed target
    input  logic        is_branch,                  // Branch opcode seen
    output opcode_t     opcode,
    output reg_idx_t    rd,
    output reg_idx_t    rs1,
    output reg_idx_t    rs2,
    output imm5_t       imm,
    output word_t       op1,
    output word_t       op2,
    output word_t       branch_target_out
);

    logic  load;                                    // Capture this edge
    logic  is_imm;                                  // I-form word
    word_t op2_next;                                // Selected second operand

    assign load   = !flush && !stall;
    assign is_imm = instr.i.imm_flag;

    // Immediate replaces rs2 value in I-form
    assign op2_next = is_imm ? imm_ext : rs2_val;

    // Common fields, cleared by flush
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            opcode <= OPC_NOP;
            rd     <= '0;
            rs1    <= '0;
        end else if (flush) begin
            opcode <= OPC_NOP;                      // Bubble
            rd     <= '0;
            rs1    <= '0;
        end else if (load) begin
            opcode <= instr.r.opcode;
            rd     <= instr.r.rd;
            rs1    <= instr.r.rs1;
        end
    end

    // Form-specific fields, the other one keeps its old value
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rs2 <= '0;
            imm <= '0;
        end else if (flush) begin
            rs2 <= '0;
            imm <= '0;
        end else if (load) begin
            if (is_imm) begin
                imm <= instr.i.imm;                 // rs2 untouched
            end else begin
                rs2 <= instr.r.rs2;                 // imm untouched
            end
        end
    end

    // Operand values
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op1 <= '0;
            op2 <= '0;
        end else if (flush) begin
            op1 <= '0;
            op2 <= '0;
        end else if (load) begin
            op1 <= rs1_val;
            op2 <= op2_next;
        end
    end

    // Target survives flush, moves only on a branch decode
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            branch_target_out <= '0;
        end else if (load && is_branch) begin
            branch_target_out <= branch_target;
        end
    end

    // A flush edge must leave a bubble behind
    a_flush_nop : assert property (
        @(posedge clk) disable iff (reset)
        flush |=> (opcode == OPC_NOP)
    ) else $error("decode_latch: opcode not NOP after flush");

    // Stalled stage must not disturb the operand handed to execute
    a_stall_hold : assert property (
        @(posedge clk) disable iff (reset)
        (stall && !flush) |=> $stable(op1)
    ) else $error("decode_latch: op1 changed during stall");

endmodule

//--- rtl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import cpu16_pkg::*; #(
    parameter int NUM_REGS = 8                      // Register file depth
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,                      // Hold decode
    input  logic        flush,                      // Squash decode
    input  word_t       pc,                         // PC of instr
    input  instr_word_u instr,                      // Fetched word
    input  logic        wr_en,                      // Writeback strobe
    input  reg_idx_t    wr_addr,
    input  word_t       wr_data,
    output opcode_t     opcode,
    output reg_idx_t    rd,
    output reg_idx_t    rs1,
    output reg_idx_t    rs2,
    output imm5_t       imm,
    output word_t       op1,
    output word_t       op2,
    output word_t       branch_target_out
);

    word_t rs1_val;                                 // Register read a
    word_t rs2_val;                                 // Register read b
    word_t imm_ext;                                 // Operand immediate
    word_t branch_target;                           // Unlatched target
    logic  is_branch;

    // Reads use the R view for both sources
    register_file #(
        .NUM_REGS  (NUM_REGS)
    ) u_regfile (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr_a (instr.r.rs1),
        .rd_addr_b (instr.r.rs2),
        .rd_data_a (rs1_val),
        .rd_data_b (rs2_val)
    );

    // Runs beside the register read, same cycle
    imm_branch_gen u_imm_gen (
        .pc            (pc),
        .instr         (instr),
        .imm_ext       (imm_ext),
        .branch_target (branch_target),
        .is_branch     (is_branch)
    );

    decode_latch u_latch (
        .clk               (clk),
        .reset             (reset),
        .stall             (stall),
        .flush             (flush),
        .instr             (instr),
        .rs1_val           (rs1_val),
        .rs2_val           (rs2_val),
        .imm_ext           (imm_ext),
        .branch_target     (branch_target),
        .is_branch         (is_branch),
        .opcode            (opcode),
        .rd                (rd),
        .rs1               (rs1),
        .rs2               (rs2),
        .imm               (imm),
        .op1               (op1),
        .op2               (op2),
        .branch_target_out (branch_target_out)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 8,                 // Clock period
    parameter int RESET_CYCLES = 3                  // Rising edges held in reset
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;        // 50 percent duty
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);                             // Release away from the active edge
        reset = 1'b0;
    end

endmodule

//--- test/decode_unit_tb.sv
`timescale 1ns/1ps

module decode_unit_tb import cpu16_pkg::*; ();

    localparam GOLDEN_PATH       = "test/decode_golden.txt";
    localparam int EDGE_LIMIT_NS = 100;             // Longest gap between two clock edges
    localparam int RESET_LIMIT   = 20;              // Cycles allowed for reset release

    logic        clk;
    logic        reset;
    logic        stall;
    logic        flush;
    word_t       pc;
    instr_word_u instr;
    logic        wr_en;
    reg_idx_t    wr_addr;
    word_t       wr_data;
    opcode_t     opcode;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    imm5_t       imm;
    word_t       op1;
    word_t       op2;
    word_t       branch_target_out;

    // One golden line of stimulus and expected values
    logic [15:0] g_stall, g_flush, g_wr_en, g_wr_addr, g_wr_data, g_pc, g_instr;
    logic [15:0] e_opcode, e_rd, e_rs1, e_rs2, e_imm, e_op1, e_op2, e_bt;

    int    fd;                                      // Golden file handle
    int    checks;
    int    errors;
    int    tests_run;
    int    tests_failed;
    int    test_errors;                             // Mismatches in current test
    int    test_steps;
    string test_name;
    bit    test_open;
    bit    aborted;                                 // Run cut short
    bit    edge_seen;

    tb_clock #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (3)
    ) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    decode_unit #(
        .NUM_REGS (8)
    ) dut0 (
        .clk               (clk),
        .reset             (reset),
        .stall             (stall),
        .flush             (flush),
        .pc                (pc),
        .instr             (instr),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .opcode            (opcode),
        .rd                (rd),
        .rs1               (rs1),
        .rs2               (rs2),
        .imm               (imm),
        .op1               (op1),
        .op2               (op2),
        .branch_target_out (branch_target_out)
    );

    task automatic check_opcode(input string name, input opcode_t expected,
                                input opcode_t actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR %s expected %h got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t expected,
                                 input reg_idx_t actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR %s expected %h got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_imm(input string name, input imm5_t expected, input imm5_t actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR %s expected %h got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR %s expected %h got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic open_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_steps  = 0;
        test_open   = 1'b1;
    endtask

    // Result line for the test just finished
    task automatic close_test();
        if (test_open) begin
            tests_run++;
            errors += test_errors;
            if (test_errors == 0) begin
                $display("Test %s: pass, %0d steps", test_name, test_steps);
            end else begin
                tests_failed++;
                $display("Test %s: FAIL, %0d mismatches in %0d steps",
                         test_name, test_errors, test_steps);
            end
            test_open = 1'b0;
        end
    endtask

    task automatic finish_run();
        close_test();
        $display("Summary: tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, checks, errors);
        if (errors == 0 && !aborted && tests_run > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // Edge wait guarded by a 1 ns polling loop
    task automatic wait_edge(input bit rising);
        edge_seen = 1'b0;
        fork
            begin
                if (rising) begin
                    @(posedge clk);
                end else begin
                    @(negedge clk);
                end
                edge_seen = 1'b1;
            end
            begin
                for (int ns = 0; ns < EDGE_LIMIT_NS && !edge_seen; ns++) begin
                    #1;
                end
            end
        join_any
        disable fork;
        if (!edge_seen) begin
            $display("Timeout: no %s clock edge within %0d ns",
                     rising ? "rising" : "falling", EDGE_LIMIT_NS);
            aborted = 1'b1;
        end
    endtask

    // Called on a falling edge and returns on the next one
    task automatic apply_step();
        if (!test_open) begin
            open_test("unnamed");
        end
        stall   = g_stall[0];
        flush   = g_flush[0];
        wr_en   = g_wr_en[0];
        wr_addr = g_wr_addr[2:0];
        wr_data = g_wr_data;
        pc      = g_pc;
        instr   = g_instr;
        wait_edge(1'b1);                            // Decode edge
        if (!aborted) begin
            wait_edge(1'b0);                        // Outputs settled
        end
        if (!aborted) begin
            test_steps++;
            check_opcode("opcode", e_opcode[3:0], opcode);
            check_reg_idx("rd", e_rd[2:0], rd);
            check_reg_idx("rs1", e_rs1[2:0], rs1);
            check_reg_idx("rs2", e_rs2[2:0], rs2);
            check_imm("imm", e_imm[4:0], imm);
            check_word("op1", e_op1, op1);
            check_word("op2", e_op2, op2);
            check_word("branch_target_out", e_bt, branch_target_out);
        end
    endtask

    task automatic run_vectors();
        string line;
        string name;
        int    line_no;
        int    fields;
        line_no = 0;
        while (!aborted && $fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.substr(0, 1) == "//") begin
                continue;                           // Blank or column note
            end
            if (line.getc(0) == "#") begin
                close_test();
                name = "unnamed";
                void'($sscanf(line, "# %s", name));
                open_test(name);
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             g_stall, g_flush, g_wr_en, g_wr_addr, g_wr_data, g_pc, g_instr,
                             e_opcode, e_rd, e_rs1, e_rs2, e_imm, e_op1, e_op2, e_bt);
            if (fields != 15) begin
                if (!test_open) begin
                    open_test("unnamed");
                end
                $display("Golden line %0d is short, only %0d of 15 fields could be read",
                         line_no, fields);
                test_errors++;
            end else begin
                apply_step();
            end
        end
    endtask

    initial begin
        int n;
        stall     = 1'b0;                           // Every input known from time zero
        flush     = 1'b0;
        pc        = '0;
        instr     = '0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        checks    = 0;
        errors    = 0;
        tests_run = 0;
        tests_failed = 0;
        test_open = 1'b0;
        aborted   = 1'b0;
        fd = $fopen(GOLDEN_PATH, "r");
        n = 0;
        do begin
            wait_edge(1'b1);
            n++;
        end while (reset && !aborted && n < RESET_LIMIT);
        if (reset && !aborted) begin
            $display("Timeout: reset still high after %0d cycles", n);
            aborted = 1'b1;
        end
        if (!aborted) begin
            wait_edge(1'b0);                        // First drive on a falling edge
        end
        if (fd == 0) begin
            $display("Could not open the golden file %s", GOLDEN_PATH);
            errors++;
        end else begin
            run_vectors();
            $fclose(fd);
        end
        finish_run();
    end

endmodule

//--- test/decode_golden.txt
// stall flush wr_en wr_addr wr_data pc instr  then expected opcode rd rs1 rs2 imm op1 op2 branch_target_out
// All fields hex, one clock step per line, lines starting with # name the test below them
# reset_state
1 0 0 0 0000 0000 0000  0 0 0 0 00 0000 0000 0000
# reg_write_r_form
0 0 1 1 1234 0000 0000  0 0 0 0 00 0000 0000 0000
0 0 1 2 abcd 0000 0000  0 0 0 0 00 0000 0000 0000
0 0 1 3 0f0f 0000 0000  0 0 0 0 00 0000 0000 0000
0 0 1 0 dead 0000 0000  0 0 0 0 00 0000 0000 0000
0 0 0 0 0000 0000 1422  1 4 1 2 00 1234 abcd 0000
0 0 0 0 0000 0000 2578  2 5 3 0 00 0f0f 0000 0000
0 0 0 0 0000 0000 3103  3 1 0 3 00 0000 0f0f 0000
# i_form
0 0 0 0 0000 0000 4a3b  4 2 1 3 1b 1234 001b 0000
0 0 0 0 0000 0000 5f5f  5 7 2 3 1f abcd 001f 0000
0 0 0 0 0000 0000 1341  1 3 2 1 1f abcd 1234 0000
# branch_target
0 0 0 0 0000 0100 c825  c 0 1 1 05 1234 0005 0114
0 0 0 0 0000 0200 c81c  c 0 0 1 1c 0000 001c 01f0
0 0 0 0 0000 0010 c810  c 0 0 1 10 0000 0010 ffd0
0 0 0 0 0000 0300 6963  6 1 3 1 03 0f0f 0003 ffd0
# stall
1 0 1 4 5a5a 0400 7284  6 1 3 1 03 0f0f 0003 ffd0
1 0 0 0 0000 0400 7284  6 1 3 1 03 0f0f 0003 ffd0
1 0 0 0 0000 0400 c805  6 1 3 1 03 0f0f 0003 ffd0
0 0 0 0 0000 0400 7284  7 2 4 4 03 5a5a 5a5a ffd0
# flush
0 1 0 0 0000 0500 c805  0 0 0 0 00 0000 0000 ffd0
0 0 0 0 0000 0000 1422  1 4 1 2 00 1234 abcd ffd0
1 1 0 0 0000 0000 1422  0 0 0 0 00 0000 0000 ffd0
# write_bypass
0 0 1 5 7777 0000 16a2  1 6 5 2 00 7777 abcd ffd0
0 0 1 2 beef 0000 1422  1 4 1 2 00 1234 beef ffd0
0 0 0 0 0000 0000 16a5  1 6 5 5 00 7777 7777 ffd0
0 0 1 0 1111 0000 3103  3 1 0 3 00 0000 0f0f ffd0

//--- compile.f
rtl/cpu16_pkg.sv
rtl/register_file.sv
rtl/imm_branch_gen.sv
rtl/decode_latch.sv
rtl/decode_unit.sv
test/tb_clock.sv
test/decode_unit_tb.sv

//--- Bender.yml
package:
  name: cpu16_decode

sources:
  - files:
      - rtl/cpu16_pkg.sv
      - rtl/register_file.sv
      - rtl/imm_branch_gen.sv
      - rtl/decode_latch.sv
      - rtl/decode_unit.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/decode_unit_tb.sv
